/* common/simd_pkg.sv */
// Shared types of the SIMD min/max slice
// Import into modules that look at a datapath word lane by lane
`include "simd_settings.svh"

package simd_pkg;

  localparam int unsigned HALF_W = `SIMD_WIDTH / `SIMD_LANES;

  // One datapath word seen as a single FP32 value or as two FP16 values
  typedef union packed {
    logic [`SIMD_WIDTH-1:0]             fp32;
    logic [`SIMD_LANES-1:0][HALF_W-1:0] fp16;  // Lane 0 in bits 15:0
  } simd_word_u;

endpackage

/* common/simd_settings.svh */
// Widths, flag positions, pipeline depth and canonical NaNs of the SIMD min/max slice
// Include wherever these values are needed
`ifndef SIMD_SETTINGS_SVH
`define SIMD_SETTINGS_SVH

`define SIMD_WIDTH     32
`define SIMD_LANES     2
`define SIMD_PIPE_REGS 2   // At least 1

// Status flag positions
`define SIMD_FLAG_W    5
`define FLAG_NV        4
`define FLAG_DZ        3
`define FLAG_OF        2
`define FLAG_UF        1
`define FLAG_NX        0

// Stage payload is result word, two flag sets, fmt_half, vectorial and mask
`define SIMD_STAGE_W   (`SIMD_WIDTH + 2*`SIMD_FLAG_W + 2 + `SIMD_LANES)

`define FP32_QNAN      32'h7fc0_0000
`define FP16_QNAN      16'h7e00

`endif

/* rtl/lane/minmax_lane.sv */
// One lane of IEEE minNum/maxNum with NaN handling and the invalid flag
// Lane 0 handles FP32 and FP16, upper lanes handle FP16 only
`timescale 1ns/1ns
`include "simd_settings.svh"

module minmax_lane
  import simd_pkg::*;
#(
  parameter bit HasFp32 = 1'b1
) (
  input  simd_word_u              a_i,
  input  simd_word_u              b_i,
  input  logic                    fmt_half_i,
  input  logic                    op_max_i,
  output logic [`SIMD_WIDTH-1:0]  res_o,
  output logic [`SIMD_FLAG_W-1:0] flags_o
);

  // An FP16-only lane is the upper lane and reads the upper half
  localparam int unsigned HALF_IDX = HasFp32 ? 0 : 1;

  logic              is_half;
  logic [HALF_W-1:0] a_h, b_h;
  logic [31:0]       key_a, key_b;  // Sign-magnitude keys, FP16 left aligned
  logic [1:0]        cls_a, cls_b;  // {nan, snan}
  logic              a_lt_b, pick_a;

  // Returns {nan, signaling nan} for either format
  function automatic logic [1:0] nan_class(logic [31:0] w, logic half);
    logic nan;
    logic quiet;
    if (half) begin
      nan   = &w[14:10] & |w[9:0];
      quiet = w[9];
    end else begin
      nan   = &w[30:23] & |w[22:0];
      quiet = w[22];
    end
    return {nan, nan & ~quiet};
  endfunction

  assign is_half = fmt_half_i | ~HasFp32;
  assign a_h     = a_i.fp16[HALF_IDX];
  assign b_h     = b_i.fp16[HALF_IDX];

  assign key_a = is_half ? {a_h, 16'h0000} : a_i.fp32;
  assign key_b = is_half ? {b_h, 16'h0000} : b_i.fp32;

  assign cls_a = nan_class(is_half ? {16'h0000, a_h} : a_i.fp32, is_half);
  assign cls_b = nan_class(is_half ? {16'h0000, b_h} : b_i.fp32, is_half);

  // ------------------------------
  // Ordering, -0 sits below +0
  // ------------------------------
  always_comb begin
    if (key_a[31] != key_b[31]) begin
      a_lt_b = key_a[31];
    end else if (key_a[31]) begin
      a_lt_b = key_a[30:0] > key_b[30:0];  // Both negative
    end else begin
      a_lt_b = key_a[30:0] < key_b[30:0];
    end
  end

  always_comb begin
    pick_a = op_max_i ? ~a_lt_b : a_lt_b;
    if (cls_a[1]) pick_a = 1'b0;  // A single NaN loses to the number
    else if (cls_b[1]) pick_a = 1'b1;

    if (cls_a[1] && cls_b[1]) begin
      res_o = is_half ? {16'hffff, `FP16_QNAN} : `FP32_QNAN;
    end else if (is_half) begin
      res_o = {16'hffff, pick_a ? a_h : b_h};  // NaN-boxed
    end else begin
      res_o = pick_a ? a_i.fp32 : b_i.fp32;
    end
  end

  always_comb begin
    flags_o          = '0;
    flags_o[`FLAG_NV] = cls_a[0] | cls_b[0];
  end

endmodule

/* rtl/operand_unpack.sv */
// Splits both operands into lane values for the min/max lanes
// FP16 scalars that are not NaN-boxed become the canonical FP16 NaN
`timescale 1ns/1ns
`include "simd_settings.svh"

module operand_unpack
  import simd_pkg::*;
(
  input  logic [`SIMD_WIDTH-1:0] operand_a_i,
  input  logic [`SIMD_WIDTH-1:0] operand_b_i,
  input  logic                   fmt_half_i,
  input  logic                   vectorial_i,
  output simd_word_u             lane_a_o,
  output simd_word_u             lane_b_o
);

  logic scalar_half;

  // A narrow scalar is valid only with all ones above it
  function automatic logic is_boxed(logic [`SIMD_WIDTH-1:0] w);
    return &w[`SIMD_WIDTH-1:HALF_W];
  endfunction

  assign scalar_half = fmt_half_i & ~vectorial_i;

  always_comb begin
    lane_a_o.fp32 = operand_a_i;  // Vectors and FP32 pass as they are
    lane_b_o.fp32 = operand_b_i;

    if (scalar_half && !is_boxed(operand_a_i)) begin
      lane_a_o.fp16[0] = `FP16_QNAN;
    end
    if (scalar_half && !is_boxed(operand_b_i)) begin
      lane_b_o.fp16[0] = `FP16_QNAN;
    end
  end

endmodule

/* rtl/pipe_stage.sv */
// One valid/ready register stage of the min/max pipeline
// Chain stages back to back, the flush clears every valid bit
`timescale 1ns/1ns
`include "simd_settings.svh"

module pipe_stage (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     flush_i,
  // Upstream side
  input  logic                     valid_i,
  output logic                     ready_o,
  input  logic [`SIMD_STAGE_W-1:0] data_i,
  // Downstream side
  output logic                     valid_o,
  input  logic                     ready_i,
  output logic [`SIMD_STAGE_W-1:0] data_o
);

  logic                     valid_q;
  logic [`SIMD_STAGE_W-1:0] data_q;
  logic                     accept;

  // Advance when the next stage takes our item or we only hold a bubble
  assign ready_o = ready_i | ~valid_q;
  assign accept  = valid_i & ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;  // Drops items taken on this edge too
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) data_q <= data_i;
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

/* rtl/result_pack.sv */
// Builds the output word from the lane results and collapses the status
// NaN-boxes scalar FP16 results, lane 1 only counts for vectors
`timescale 1ns/1ns
`include "simd_settings.svh"

module result_pack
  import simd_pkg::*;
(
  input  logic [`SIMD_WIDTH-1:0]  res0_i,
  input  logic [`SIMD_WIDTH-1:0]  res1_i,
  input  logic [`SIMD_FLAG_W-1:0] flags0_i,
  input  logic [`SIMD_FLAG_W-1:0] flags1_i,
  input  logic                    fmt_half_i,
  input  logic                    vectorial_i,
  input  logic [`SIMD_LANES-1:0]  simd_mask_i,
  output logic [`SIMD_WIDTH-1:0]  result_o,
  output logic [`SIMD_FLAG_W-1:0] status_o
);

  simd_word_u packed_w;

  always_comb begin
    packed_w.fp32 = res0_i;  // FP32 takes lane 0 as is
    if (fmt_half_i) begin
      packed_w.fp16[0] = res0_i[HALF_W-1:0];
      packed_w.fp16[1] = vectorial_i ? res1_i[HALF_W-1:0] : 16'hffff;
    end
  end

  assign result_o = packed_w.fp32;

  // Masked OR over lanes
  assign status_o = (flags0_i & {`SIMD_FLAG_W{simd_mask_i[0]}})
                  | (flags1_i & {`SIMD_FLAG_W{simd_mask_i[1] & vectorial_i}});

endmodule

/* rtl/simd_minmax_top.sv */
// Two-lane SIMD floating-point min/max slice, one FP32 or two FP16 values per word
// Valid/ready on both sides, SIMD_PIPE_REGS register stages, synchronous flush
`timescale 1ns/1ns
`include "simd_settings.svh"

module simd_minmax_top
  import simd_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic [`SIMD_WIDTH-1:0]  operand_a_i,
  input  logic [`SIMD_WIDTH-1:0]  operand_b_i,
  input  logic                    op_max_i,     // 1 max, 0 min
  input  logic                    fmt_half_i,
  input  logic                    vectorial_i,
  input  logic [`SIMD_LANES-1:0]  simd_mask_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  input  logic                    flush_i,
  output logic [`SIMD_WIDTH-1:0]  result_o,
  output logic [`SIMD_FLAG_W-1:0] status_o,
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output logic                    busy_o
);

  localparam int unsigned NREGS = `SIMD_PIPE_REGS;

  logic                     vectorial;
  simd_word_u               lane_a, lane_b;
  logic [`SIMD_WIDTH-1:0]   res0, res1;
  logic [`SIMD_FLAG_W-1:0]  flags0, flags1;
  simd_word_u               lane_word;

  // Index i holds the signals after i stages
  logic [NREGS:0]                        stg_valid, stg_ready;
  logic [NREGS:0][`SIMD_STAGE_W-1:0]     stg_data;

  logic [`SIMD_WIDTH-1:0]  out_word;
  logic [`SIMD_FLAG_W-1:0] out_flags0, out_flags1;
  logic                    out_half, out_vec;
  logic [`SIMD_LANES-1:0]  out_mask;

  // ------------------------------
  // Input side and lanes
  // ------------------------------
  assign vectorial = vectorial_i & fmt_half_i;  // Vectors exist only for FP16

  operand_unpack u_unpack (
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .fmt_half_i  (fmt_half_i),
    .vectorial_i (vectorial),
    .lane_a_o    (lane_a),
    .lane_b_o    (lane_b)
  );

  minmax_lane #(.HasFp32(1'b1)) u_lane0 (
    .a_i        (lane_a),
    .b_i        (lane_b),
    .fmt_half_i (fmt_half_i),
    .op_max_i   (op_max_i),
    .res_o      (res0),
    .flags_o    (flags0)
  );

  minmax_lane #(.HasFp32(1'b0)) u_lane1 (
    .a_i        (lane_a),
    .b_i        (lane_b),
    .fmt_half_i (fmt_half_i),
    .op_max_i   (op_max_i),
    .res_o      (res1),
    .flags_o    (flags1)
  );

  // Lane 1's half rides in the upper half of the staged word
  always_comb begin
    lane_word.fp32 = res0;
    if (fmt_half_i) lane_word.fp16[1] = res1[HALF_W-1:0];
  end

  // ------------------------------
  // Register stages
  // ------------------------------
  assign stg_valid[0] = in_valid_i;
  assign stg_data[0]  = {lane_word.fp32, flags1, flags0, fmt_half_i, vectorial, simd_mask_i};
  assign in_ready_o   = stg_ready[0];

  for (genvar i = 0; i < NREGS; i++) begin : gen_stage
    pipe_stage u_stage (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .flush_i (flush_i),
      .valid_i (stg_valid[i]),
      .ready_o (stg_ready[i]),
      .data_i  (stg_data[i]),
      .valid_o (stg_valid[i+1]),
      .ready_i (stg_ready[i+1]),
      .data_o  (stg_data[i+1])
    );
  end

  assign stg_ready[NREGS] = out_ready_i;
  assign out_valid_o      = stg_valid[NREGS];
  assign busy_o           = |stg_valid[NREGS:1];

  // ------------------------------
  // Output side
  // ------------------------------
  assign {out_word, out_flags1, out_flags0, out_half, out_vec, out_mask} = stg_data[NREGS];

  result_pack u_pack (
    .res0_i      (out_word),
    .res1_i      ({16'hffff, out_word[`SIMD_WIDTH-1:HALF_W]}),
    .flags0_i    (out_flags0),
    .flags1_i    (out_flags1),
    .fmt_half_i  (out_half),
    .vectorial_i (out_vec),
    .simd_mask_i (out_mask),
    .result_o    (result_o),
    .status_o    (status_o)
  );

endmodule

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f \
    --top-module tb_simd_minmax -Mdir obj_dir \
  && { out="$(./obj_dir/Vtb_simd_minmax)"; \
       printf '%s\n' "$out"; \
       grep -qx "Simulation finished: PASS" <<< "$out"; } \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed" >&2; exit 1; }

/* sim/simd_minmax_properties.sv */
// Handshake and reset assertions for the SIMD min/max slice
// Bound to simd_minmax_top from this file
`timescale 1ns/1ns

module simd_minmax_properties (
  input logic        clk_i,
  input logic        rst_n_i,
  input logic        flush_i,
  input logic        in_valid_i,
  input logic        in_ready_o,
  input logic        out_valid_o,
  input logic        out_ready_i,
  input logic        busy_o,
  input logic [31:0] result_o,
  input logic [4:0]  status_o
);

  int unsigned assert_fails;  // Failed assertions so far

  // A stalled result stays put until it is taken
  hold_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i && !flush_i |=>
      out_valid_o && $stable(result_o) && $stable(status_o))
    else begin
      assert_fails++;
      $error("output changed while stalled");
    end

  // Idle in the cycle after a reset edge
  reset_idle: assert property (@(posedge clk_i)
    !rst_n_i |=> !out_valid_o && !busy_o && in_ready_o)
    else begin
      assert_fails++;
      $error("pipeline not idle after reset");
    end

  // An accepted item makes the pipeline busy on the next cycle
  busy_on_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    in_valid_i && in_ready_o && !flush_i |=> busy_o)
    else begin
      assert_fails++;
      $error("busy_o low after an item was accepted");
    end

endmodule

bind simd_minmax_top simd_minmax_properties u_props (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .flush_i     (flush_i),
  .in_valid_i  (in_valid_i),
  .in_ready_o  (in_ready_o),
  .out_valid_o (out_valid_o),
  .out_ready_i (out_ready_i),
  .busy_o      (busy_o),
  .result_o    (result_o),
  .status_o    (status_o)
);

/* sim/tb_simd_minmax.sv */
// Randomized testbench for the SIMD min/max slice with a reference model and scoreboard
// Compile with verilog.f and tb_simd_minmax as top, or use run.sh
`timescale 1ns/1ns
`include "simd_settings.svh"

module tb_simd_minmax;

  localparam int N_ITEMS      = 600;
  localparam int RESET_CYCLES = 16;
  localparam int WATCHDOG_NS  = (N_ITEMS * 10 + RESET_CYCLES) * 20;

  logic                    clk;
  logic                    rst_n;
  logic [`SIMD_WIDTH-1:0]  operand_a, operand_b;
  logic                    op_max, fmt_half, vectorial;
  logic [`SIMD_LANES-1:0]  simd_mask;
  logic                    in_valid, in_ready, flush, out_ready, out_valid, busy;
  logic [`SIMD_WIDTH-1:0]  result;
  logic [`SIMD_FLAG_W-1:0] status;

  logic [31:0] lfsr = 32'hd52c_c344;
  logic [36:0] exp_q[$];                          // {status, result} per item in flight
  int          sent, pushed, dropped, n_out, errors;
  bit          busy_check;                        // Flush seen on the previous edge

  simd_minmax_top DUT (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .operand_a_i (operand_a),
    .operand_b_i (operand_b),
    .op_max_i    (op_max),
    .fmt_half_i  (fmt_half),
    .vectorial_i (vectorial),
    .simd_mask_i (simd_mask),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .flush_i     (flush),
    .result_o    (result),
    .status_o    (status),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .busy_o      (busy)
  );

  always #10 clk = ~clk;

  // ------------------------------
  // Random source
  // ------------------------------
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
  endfunction

  task automatic draw(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic pick_half(output logic [15:0] v);
    logic [31:0] r;
    draw(2, r);
    if (r[1:0] != 2'd0) begin
      draw(16, r);
      v = r[15:0];
    end else begin
      draw(3, r);
      case (r[2:0])
        3'd0:    v = 16'h0000;
        3'd1:    v = 16'h8000;
        3'd2:    v = 16'h7e00;                    // Quiet NaN
        3'd3:    v = 16'h7d00;                    // Signaling NaN
        3'd4:    v = 16'h7c00;
        3'd5:    v = 16'hfc00;
        3'd6:    v = 16'h3c00;
        default: v = 16'hbc00;
      endcase
    end
  endtask

  task automatic pick_single(output logic [31:0] v);
    logic [31:0] r;
    draw(2, r);
    if (r[1:0] != 2'd0) begin
      draw(32, v);
    end else begin
      draw(3, r);
      case (r[2:0])
        3'd0:    v = 32'h0000_0000;
        3'd1:    v = 32'h8000_0000;
        3'd2:    v = 32'h7fc0_0000;
        3'd3:    v = 32'h7fa0_0000;               // Signaling NaN
        3'd4:    v = 32'h7f80_0000;
        3'd5:    v = 32'hff80_0000;
        3'd6:    v = 32'h3f80_0000;
        default: v = 32'hbf80_0000;
      endcase
    end
  endtask

  task automatic make_operand(input logic half, input logic vec, output logic [31:0] v);
    logic [15:0] lo, hi;
    logic [31:0] r;
    if (!half) begin
      pick_single(v);
    end else begin
      pick_half(lo);
      pick_half(hi);
      draw(2, r);
      if (!vec && r[1:0] != 2'd0) hi = 16'hffff;  // Scalars are mostly boxed
      v = {hi, lo};
    end
  endtask

  // ------------------------------
  // Reference model
  // ------------------------------
  // Maps IEEE values onto an unsigned order, -0 lands just below +0
  function automatic logic [31:0] order_key(logic [31:0] x);
    return x[31] ? ~x : {1'b1, x[30:0]};
  endfunction

  // FP16 values arrive left aligned in w
  function automatic logic is_nan(logic [31:0] w, logic half);
    return half ? (&w[30:26] && |w[25:16]) : (&w[30:23] && |w[22:0]);
  endfunction

  function automatic logic is_snan(logic [31:0] w, logic half);
    return is_nan(w, half) && !(half ? w[25] : w[22]);
  endfunction

  // Returns {nv, value}, an FP16 value sits in bits 15:0
  function automatic logic [32:0] lane_model(logic [31:0] a, logic [31:0] b,
                                             logic half, logic is_max);
    logic [31:0] wa, wb, r;
    logic        nv;
    wa = half ? {a[15:0], 16'h0000} : a;
    wb = half ? {b[15:0], 16'h0000} : b;
    nv = is_snan(wa, half) | is_snan(wb, half);
    if (is_nan(wa, half) && is_nan(wb, half)) r = half ? {`FP16_QNAN, 16'h0000} : `FP32_QNAN;
    else if (is_nan(wa, half)) r = wb;
    else if (is_nan(wb, half)) r = wa;
    else if ((order_key(wa) < order_key(wb)) != is_max) r = wa;
    else r = wb;
    return {nv, half ? {16'h0000, r[31:16]} : r};
  endfunction

  function automatic logic [36:0] item_model(logic [31:0] a, logic [31:0] b, logic is_max,
                                             logic half, logic vec_in, logic [1:0] mask);
    logic [32:0] l0, l1;
    logic [15:0] a0, b0;
    logic [31:0] res;
    logic        nv;
    if (!half) begin
      l0  = lane_model(a, b, 1'b0, is_max);
      res = l0[31:0];
      nv  = l0[32] & mask[0];
    end else if (vec_in) begin
      l0  = lane_model({16'h0, a[15:0]}, {16'h0, b[15:0]}, 1'b1, is_max);
      l1  = lane_model({16'h0, a[31:16]}, {16'h0, b[31:16]}, 1'b1, is_max);
      res = {l1[15:0], l0[15:0]};
      nv  = (l0[32] & mask[0]) | (l1[32] & mask[1]);
    end else begin
      a0  = (a[31:16] == 16'hffff) ? a[15:0] : `FP16_QNAN;  // Unboxed means NaN
      b0  = (b[31:16] == 16'hffff) ? b[15:0] : `FP16_QNAN;
      l0  = lane_model({16'h0, a0}, {16'h0, b0}, 1'b1, is_max);
      res = {16'hffff, l0[15:0]};
      nv  = l0[32] & mask[0];
    end
    return {5'(nv) << `FLAG_NV, res};
  endfunction

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, want);
    end
  endtask

  // ------------------------------
  // Scoreboard and driver
  // ------------------------------
  always @(posedge clk) begin : drive
    logic [31:0] r, a_new, b_new;
    logic [36:0] want;
    logic        half_n, vec_n;
    if (rst_n) begin
      if (busy_check) compare("busy_o after flush", 32'(busy), 32'd0);
      busy_check = flush;
      if (out_valid && out_ready) begin
        n_out++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("Error at %0t: a result came out with no item in flight", $time);
        end else begin
          want = exp_q.pop_front();
          compare("result_o", result, want[31:0]);
          compare("status_o", 32'(status), 32'(want[36:32]));
        end
      end
      if (flush) begin
        dropped += exp_q.size();
        exp_q.delete();
      end
      if (in_valid && in_ready) begin
        sent++;
        if (!flush) begin
          exp_q.push_back(item_model(operand_a, operand_b, op_max, fmt_half,
                                     vectorial & fmt_half, simd_mask));
          pushed++;
        end
      end

      if (sent >= N_ITEMS) begin
        in_valid  <= 1'b0;
        flush     <= 1'b0;
        out_ready <= 1'b1;                        // Drain
      end else begin
        draw(2, r);
        out_ready <= r[1:0] != 2'd0;
        draw(6, r);
        flush <= r[5:0] == 6'd0;
        if (!in_valid || in_ready) begin          // Otherwise hold the pending item
          draw(3, r);
          in_valid <= r[2:0] != 3'd0;
          draw(3, r);
          op_max    <= r[0];
          half_n     = r[1];
          vec_n      = r[2];
          fmt_half  <= half_n;
          vectorial <= vec_n;
          draw(2, r);
          simd_mask <= r[1:0];
          make_operand(half_n, vec_n & half_n, a_new);
          make_operand(half_n, vec_n & half_n, b_new);
          operand_a <= a_new;
          operand_b <= b_new;
        end
      end
    end
  end

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    operand_a = '0;
    operand_b = '0;
    op_max    = 1'b0;
    fmt_half  = 1'b0;
    vectorial = 1'b0;
    simd_mask = '1;
    in_valid  = 1'b0;
    flush     = 1'b0;
    out_ready = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    while (sent < N_ITEMS || exp_q.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);
    compare("busy_o after drain", 32'(busy), 32'd0);
    compare("out_valid_o after drain", 32'(out_valid), 32'd0);
    compare("result count", 32'(n_out), 32'(pushed - dropped));

    $display("sent %0d, checked %0d, flushed %0d, errors %0d, assertion failures %0d",
             sent, n_out, dropped + sent - pushed, errors, DUT.u_props.assert_fails);
    if (errors == 0 && DUT.u_props.assert_fails == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Error: timed out after %0d ns before all items came out", WATCHDOG_NS);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+common
common/simd_pkg.sv
rtl/operand_unpack.sv
rtl/lane/minmax_lane.sv
rtl/pipe_stage.sv
rtl/result_pack.sv
rtl/simd_minmax_top.sv
sim/simd_minmax_properties.sv
sim/tb_simd_minmax.sv
